//--- design/sgmii_rx_pkg.sv
package sgmii_rx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Symbol framing

	// One 8b/10b code group
	localparam int symbol_width = 10;

	// Widest bit group the CDR hands over per cycle
	localparam int chunk_max = 5;

	////////////////////////////////////////////////////////////////////////////
	// Special code groups

	// Comma, first byte of every ordered set
	localparam logic [7:0] k28_5 = 8'hbc;

	// Packet delimiters and in-band error
	localparam logic [7:0] k27_7_start = 8'hfb;
	localparam logic [7:0] k29_7_end = 8'hfd;
	localparam logic [7:0] k23_7_carrier = 8'hf7;
	localparam logic [7:0] k30_7_error = 8'hfe;

	// Second byte of /C1/ /C2/ /I1/ /I2/
	localparam logic [7:0] d21_5_c1 = 8'hb5;
	localparam logic [7:0] d2_2_c2 = 8'h42;
	localparam logic [7:0] d5_6_i1 = 8'hc5;
	localparam logic [7:0] d16_2_i2 = 8'h50;

	////////////////////////////////////////////////////////////////////////////
	// Synchronization and auto-negotiation

	localparam int sync_commas = 3;
	localparam int sync_loss_errors = 4;
	localparam int slip_timeout = 20;
	localparam int cfg_match_count = 3;

	// Sync FSM states
	localparam logic [1:0] sync_hunt = 2'd0;
	localparam logic [1:0] sync_acquire = 2'd1;
	localparam logic [1:0] sync_locked = 2'd2;

	// Speed codes, same as config word bits 11:10
	localparam logic [1:0] speed_10m = 2'd0;
	localparam logic [1:0] speed_100m = 2'd1;
	localparam logic [1:0] speed_1000m = 2'd2;

	// SGMII config word fields
	localparam int cfg_link_bit = 15;
	localparam int cfg_speed_lsb = 10;

endpackage

//--- design/sgmii_rx_gearbox.sv
`timescale 1ns/100ps

module sgmii_rx_gearbox (
	input  logic clk_312p5mhz,
	input  logic rst,
	input  logic [sgmii_rx_pkg::chunk_max-1:0] rx_bits,
	input  logic [2:0] rx_bit_count,
	input  logic bitslip,
	output logic [sgmii_rx_pkg::symbol_width-1:0] symbol,
	output logic symbol_valid
);

	// Room for 9 leftover bits plus a full chunk, oldest bit leftmost
	logic [sgmii_rx_pkg::symbol_width+sgmii_rx_pkg::chunk_max-1:0] shift_q;
	logic [sgmii_rx_pkg::symbol_width+sgmii_rx_pkg::chunk_max-1:0] shift_app;
	logic [sgmii_rx_pkg::symbol_width+sgmii_rx_pkg::chunk_max-1:0] shifted;
	logic [3:0] fill_q;
	logic [3:0] fill_app;
	logic [3:0] fill_slip;
	logic [3:0] fill_d;
	logic       take;

	always_comb begin
		shift_app = shift_q;
		fill_app = fill_q;

		// New bits enter from the right
		case (rx_bit_count)
			3'd3: begin
				shift_app = {shift_q[11:0], rx_bits[2:0]};
				fill_app = fill_q + 4'd3;
			end
			3'd4: begin
				shift_app = {shift_q[10:0], rx_bits[3:0]};
				fill_app = fill_q + 4'd4;
			end
			3'd5: begin
				shift_app = {shift_q[9:0], rx_bits[4:0]};
				fill_app = fill_q + 4'd5;
			end
			// Count of zero, nothing this cycle
			default: begin
			end
		endcase

		// Slip forgets the oldest bit, so the boundary moves one bit later
		fill_slip = (bitslip && fill_app != 4'd0) ? fill_app - 4'd1 : fill_app;

		// Full symbol available
		take = fill_slip >= 4'(sgmii_rx_pkg::symbol_width);
		fill_d = take ? fill_slip - 4'(sgmii_rx_pkg::symbol_width) : fill_slip;

		// Oldest 10 valid bits end up in the low positions
		shifted = shift_app >> fill_d;
	end

	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			fill_q <= 4'd0;
			symbol_valid <= 1'b0;
		end else begin
			fill_q <= fill_d;
			symbol_valid <= take;
		end
	end

	always_ff @(posedge clk_312p5mhz) begin
		shift_q <= shift_app;
		if (take)
			symbol <= shifted[sgmii_rx_pkg::symbol_width-1:0];
	end

endmodule

//--- design/sgmii_8b10b_decoder.sv
`timescale 1ns/100ps

module sgmii_8b10b_decoder (
	input  logic clk_312p5mhz,
	input  logic rst,
	input  logic [sgmii_rx_pkg::symbol_width-1:0] symbol,
	input  logic symbol_valid,
	output logic code_valid,
	output logic [7:0] code_byte,
	output logic code_is_k,
	output logic code_err,
	output logic disp_err
);

	// 6b sub-block abcdei to EDCBA, top bit flags a legal code
	function automatic logic [5:0] dec_6b(input logic [5:0] code);
		case (code)
			6'b100111, 6'b011000: dec_6b = {1'b1, 5'd0};
			6'b011101, 6'b100010: dec_6b = {1'b1, 5'd1};
			6'b101101, 6'b010010: dec_6b = {1'b1, 5'd2};
			6'b110001: dec_6b = {1'b1, 5'd3};
			6'b110101, 6'b001010: dec_6b = {1'b1, 5'd4};
			6'b101001: dec_6b = {1'b1, 5'd5};
			6'b011001: dec_6b = {1'b1, 5'd6};
			6'b111000, 6'b000111: dec_6b = {1'b1, 5'd7};
			6'b111001, 6'b000110: dec_6b = {1'b1, 5'd8};
			6'b100101: dec_6b = {1'b1, 5'd9};
			6'b010101: dec_6b = {1'b1, 5'd10};
			6'b110100: dec_6b = {1'b1, 5'd11};
			6'b001101: dec_6b = {1'b1, 5'd12};
			6'b101100: dec_6b = {1'b1, 5'd13};
			6'b011100: dec_6b = {1'b1, 5'd14};
			6'b010111, 6'b101000: dec_6b = {1'b1, 5'd15};
			6'b011011, 6'b100100: dec_6b = {1'b1, 5'd16};
			6'b100011: dec_6b = {1'b1, 5'd17};
			6'b010011: dec_6b = {1'b1, 5'd18};
			6'b110010: dec_6b = {1'b1, 5'd19};
			6'b001011: dec_6b = {1'b1, 5'd20};
			6'b101010: dec_6b = {1'b1, 5'd21};
			6'b011010: dec_6b = {1'b1, 5'd22};
			6'b111010, 6'b000101: dec_6b = {1'b1, 5'd23};
			6'b110011, 6'b001100: dec_6b = {1'b1, 5'd24};
			6'b100110: dec_6b = {1'b1, 5'd25};
			6'b010110: dec_6b = {1'b1, 5'd26};
			6'b110110, 6'b001001: dec_6b = {1'b1, 5'd27};
			// D.28 and the K28 comma forms
			6'b001110, 6'b001111, 6'b110000: dec_6b = {1'b1, 5'd28};
			6'b101110, 6'b010001: dec_6b = {1'b1, 5'd29};
			6'b011110, 6'b100001: dec_6b = {1'b1, 5'd30};
			6'b101011, 6'b010100: dec_6b = {1'b1, 5'd31};
			default: dec_6b = 6'd0;
		endcase
	endfunction

	// 4b sub-block fghj to HGF, primary and alternate x.7 both map to 7
	function automatic logic [3:0] dec_4b(input logic [3:0] code);
		case (code)
			4'b1011, 4'b0100: dec_4b = {1'b1, 3'd0};
			4'b1001: dec_4b = {1'b1, 3'd1};
			4'b0101: dec_4b = {1'b1, 3'd2};
			4'b1100, 4'b0011: dec_4b = {1'b1, 3'd3};
			4'b1101, 4'b0010: dec_4b = {1'b1, 3'd4};
			4'b1010: dec_4b = {1'b1, 3'd5};
			4'b0110: dec_4b = {1'b1, 3'd6};
			4'b1110, 4'b0001, 4'b0111, 4'b1000: dec_4b = {1'b1, 3'd7};
			default: dec_4b = 4'd0;
		endcase
	endfunction

	logic [5:0] abcdei;
	logic [3:0] fghj;
	logic [3:0] fghj_eff;
	logic [5:0] res_6b;
	logic [3:0] res_4b;
	logic       is_k28;
	logic       is_kx7;
	logic [2:0] ones_6b;
	logic [2:0] ones_4b;
	logic       bad_6b;
	logic       bad_4b;
	// Running disparity, low means negative
	logic       rd_q;
	logic       rd_mid;
	logic       rd_next;

	always_comb begin
		abcdei = symbol[9:4];
		fghj = symbol[3:0];
		is_k28 = (abcdei == 6'b001111) || (abcdei == 6'b110000);
		// Negative K28 form carries the complement of the data 4b table
		fghj_eff = (abcdei == 6'b110000) ? ~fghj : fghj;
		res_6b = dec_6b(abcdei);
		res_4b = dec_4b(fghj_eff);
		// K23/27/29/30 .7 use the alternate x.7 pattern
		is_kx7 = ((fghj == 4'b0111) || (fghj == 4'b1000)) &&
			(res_6b[4:0] == 5'd23 || res_6b[4:0] == 5'd27 ||
			res_6b[4:0] == 5'd29 || res_6b[4:0] == 5'd30);

		// Disparity per sub-block
		ones_6b = 3'($countones(abcdei));
		ones_4b = 3'($countones(fghj));
		// Unbalanced sub-block must point away from current disparity
		bad_6b = (ones_6b > 3'd3 && rd_q) || (ones_6b < 3'd3 && !rd_q) ||
			(abcdei == 6'b111000 && rd_q) || (abcdei == 6'b000111 && !rd_q);
		rd_mid = (ones_6b == 3'd3) ? rd_q : (ones_6b > 3'd3);
		bad_4b = (ones_4b > 3'd2 && rd_mid) || (ones_4b < 3'd2 && !rd_mid) ||
			(fghj == 4'b1100 && rd_mid) || (fghj == 4'b0011 && !rd_mid);
		rd_next = (ones_4b == 3'd2) ? rd_mid : (ones_4b > 3'd2);
	end

	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			code_valid <= 1'b0;
			code_err <= 1'b0;
			disp_err <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			code_valid <= symbol_valid;
			code_err <= symbol_valid && !(res_6b[5] && res_4b[3]);
			disp_err <= symbol_valid && (bad_6b || bad_4b);
			if (symbol_valid)
				rd_q <= rd_next;
		end
	end

	// Decoded byte is HGF EDCBA
	always_ff @(posedge clk_312p5mhz) begin
		if (symbol_valid) begin
			code_byte <= {res_4b[2:0], res_6b[4:0]};
			code_is_k <= is_k28 || is_kx7;
		end
	end

endmodule

//--- design/sgmii_rx_ctrl.sv
`timescale 1ns/100ps

module sgmii_rx_ctrl (
	input  logic clk_312p5mhz,
	input  logic rst,
	input  logic code_valid,
	input  logic [7:0] code_byte,
	input  logic code_is_k,
	input  logic code_err,
	input  logic disp_err,
	output logic bitslip,
	output logic synced,
	output logic link_up,
	output logic [1:0] link_speed
);

	logic [1:0]  state;
	logic [1:0]  comma_cnt;
	logic [2:0]  err_cnt;
	logic [1:0]  good_run;
	// Offset parity of the incoming symbol from the last comma
	logic        pos_odd;
	logic [4:0]  slip_cnt;
	logic [1:0]  os_pos;
	logic [7:0]  cfg_lo;
	logic [15:0] cfg_word;
	logic [15:0] last_word;
	logic        cfg_strobe;
	logic        idle_strobe;
	logic [1:0]  match_cnt;
	logic [1:0]  speed_code;
	logic        is_comma;
	logic        sym_bad;

	always_comb begin
		is_comma = code_valid && code_is_k && code_byte == sgmii_rx_pkg::k28_5 && !code_err;
		sym_bad = code_err || disp_err;
		// Reserved speed field falls back to 10 Mb/s
		case (cfg_word[sgmii_rx_pkg::cfg_speed_lsb +: 2])
			sgmii_rx_pkg::speed_1000m: speed_code = sgmii_rx_pkg::speed_1000m;
			sgmii_rx_pkg::speed_100m: speed_code = sgmii_rx_pkg::speed_100m;
			default: speed_code = sgmii_rx_pkg::speed_10m;
		endcase
	end

	assign synced = (state == sgmii_rx_pkg::sync_locked);

	////////////////////////////////////////////////////////////////////////////
	// Comma sync FSM

	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			state <= sgmii_rx_pkg::sync_hunt;
			comma_cnt <= 2'd0;
			err_cnt <= 3'd0;
			good_run <= 2'd0;
			pos_odd <= 1'b0;
		end else if (code_valid) begin
			pos_odd <= is_comma ? 1'b1 : ~pos_odd;
			case (state)
				sgmii_rx_pkg::sync_hunt: begin
					if (is_comma) begin
						state <= sgmii_rx_pkg::sync_acquire;
						comma_cnt <= 2'd1;
					end
				end
				sgmii_rx_pkg::sync_acquire: begin
					if (code_err) begin
						state <= sgmii_rx_pkg::sync_hunt;
						comma_cnt <= 2'd0;
					end else if (is_comma) begin
						// Odd offset, this comma starts a new count
						if (pos_odd)
							comma_cnt <= 2'd1;
						else if (comma_cnt == 2'(sgmii_rx_pkg::sync_commas - 1)) begin
							state <= sgmii_rx_pkg::sync_locked;
							comma_cnt <= 2'd0;
							err_cnt <= 3'd0;
							good_run <= 2'd0;
						end else
							comma_cnt <= comma_cnt + 2'd1;
					end
				end
				sgmii_rx_pkg::sync_locked: begin
					if (sym_bad) begin
						good_run <= 2'd0;
						if (err_cnt == 3'(sgmii_rx_pkg::sync_loss_errors - 1)) begin
							state <= sgmii_rx_pkg::sync_hunt;
							err_cnt <= 3'd0;
						end else
							err_cnt <= err_cnt + 3'd1;
					end else if (good_run == 2'd3) begin
						// Four clean symbols in a row forgive one error
						good_run <= 2'd0;
						if (err_cnt != 3'd0)
							err_cnt <= err_cnt - 3'd1;
					end else
						good_run <= good_run + 2'd1;
				end
				default: state <= sgmii_rx_pkg::sync_hunt;
			endcase
		end
	end

	// Slip timer, only runs before lock and restarts on any comma
	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			slip_cnt <= 5'd0;
			bitslip <= 1'b0;
		end else begin
			bitslip <= 1'b0;
			if (synced || is_comma)
				slip_cnt <= 5'd0;
			else if (code_valid) begin
				if (slip_cnt == 5'(sgmii_rx_pkg::slip_timeout - 1)) begin
					bitslip <= 1'b1;
					slip_cnt <= 5'd0;
				end else
					slip_cnt <= slip_cnt + 5'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Ordered sets and link tracking

	// Position 1 is the set byte, 2 and 3 the config word low and high
	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			os_pos <= 2'd0;
			cfg_strobe <= 1'b0;
			idle_strobe <= 1'b0;
		end else begin
			cfg_strobe <= 1'b0;
			idle_strobe <= 1'b0;
			if (is_comma)
				os_pos <= 2'd1;
			else if (code_valid && (code_err || code_is_k))
				os_pos <= 2'd0;
			else if (code_valid) begin
				case (os_pos)
					2'd1: begin
						if (code_byte == sgmii_rx_pkg::d21_5_c1 || code_byte == sgmii_rx_pkg::d2_2_c2)
							os_pos <= 2'd2;
						else
							os_pos <= 2'd0;
						idle_strobe <= code_byte == sgmii_rx_pkg::d5_6_i1 ||
							code_byte == sgmii_rx_pkg::d16_2_i2;
					end
					2'd2: os_pos <= 2'd3;
					2'd3: begin
						os_pos <= 2'd0;
						cfg_strobe <= 1'b1;
					end
					default: os_pos <= 2'd0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_312p5mhz) begin
		if (code_valid && os_pos == 2'd2)
			cfg_lo <= code_byte;
		if (code_valid && os_pos == 2'd3)
			cfg_word <= {code_byte, cfg_lo};
		if (cfg_strobe)
			last_word <= cfg_word;
	end

	// Idles break a run of matching config words
	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			link_up <= 1'b0;
			link_speed <= sgmii_rx_pkg::speed_10m;
			match_cnt <= 2'd0;
		end else if (!synced) begin
			link_up <= 1'b0;
			match_cnt <= 2'd0;
		end else if (idle_strobe)
			match_cnt <= 2'd0;
		else if (cfg_strobe) begin
			if (!cfg_word[sgmii_rx_pkg::cfg_link_bit]) begin
				link_up <= 1'b0;
				match_cnt <= 2'd0;
			end else if (match_cnt != 2'd0 && cfg_word == last_word) begin
				if (match_cnt == 2'(sgmii_rx_pkg::cfg_match_count - 1)) begin
					link_up <= 1'b1;
					link_speed <= speed_code;
				end else
					match_cnt <= match_cnt + 2'd1;
			end else
				match_cnt <= 2'd1;
		end
	end

endmodule

//--- design/sgmii_gmii_rx.sv
`timescale 1ns/100ps

module sgmii_gmii_rx (
	input  logic clk_312p5mhz,
	input  logic rst,
	input  logic synced,
	input  logic code_valid,
	input  logic [7:0] code_byte,
	input  logic code_is_k,
	input  logic code_err,
	input  logic disp_err,
	output logic rx_dv,
	output logic rx_er,
	output logic [7:0] rxd
);

	logic in_frame;
	logic is_start;
	logic is_end;
	logic is_fault;

	always_comb begin
		is_start = code_is_k && code_byte == sgmii_rx_pkg::k27_7_start && !code_err;
		// Terminate or carrier extend both close the frame quietly
		is_end = code_is_k && !code_err &&
			(code_byte == sgmii_rx_pkg::k29_7_end || code_byte == sgmii_rx_pkg::k23_7_carrier);
		is_fault = code_err || disp_err || (code_is_k && code_byte == sgmii_rx_pkg::k30_7_error);
	end

	always_ff @(posedge clk_312p5mhz) begin
		if (rst) begin
			in_frame <= 1'b0;
			rx_dv <= 1'b0;
			rx_er <= 1'b0;
		end else begin
			rx_dv <= 1'b0;
			rx_er <= 1'b0;
			// Losing lock aborts any frame in progress
			if (!synced)
				in_frame <= 1'b0;
			else if (code_valid) begin
				if (is_start) begin
					in_frame <= 1'b1;
					rx_dv <= 1'b1;
				end else if (in_frame) begin
					if (is_fault) begin
						rx_dv <= 1'b1;
						rx_er <= 1'b1;
					end else if (is_end)
						in_frame <= 1'b0;
					else if (code_is_k) begin
						// Stray control char such as a comma truncates the frame
						in_frame <= 1'b0;
						rx_dv <= 1'b1;
						rx_er <= 1'b1;
					end else
						rx_dv <= 1'b1;
				end
			end
		end
	end

	// Start symbol stands in for the first preamble byte
	always_ff @(posedge clk_312p5mhz) begin
		if (code_valid)
			rxd <= is_start ? 8'h55 : code_byte;
	end

endmodule

//--- design/sgmii_rx_top.sv
`timescale 1ns/100ps

module sgmii_rx_top (
	input  logic clk_312p5mhz,
	input  logic rst,
	input  logic [sgmii_rx_pkg::chunk_max-1:0] rx_bits,
	input  logic [2:0] rx_bit_count,
	output logic rx_dv,
	output logic rx_er,
	output logic [7:0] rxd,
	output logic link_up,
	output logic [1:0] link_speed,
	output logic synced
);

	// Gearbox to decoder, slip back from control
	logic [sgmii_rx_pkg::symbol_width-1:0] symbol;
	logic                                  symbol_valid;
	logic                                  bitslip;

	// Decoder fan-out to control and GMII side
	logic       code_valid;
	logic [7:0] code_byte;
	logic       code_is_k;
	logic       code_err;
	logic       disp_err;

	// Port names match the nets above
	sgmii_rx_gearbox gearbox_i (.*);

	sgmii_8b10b_decoder decoder_i (.*);

	sgmii_rx_ctrl ctrl_i (.*);

	sgmii_gmii_rx gmii_i (.*);

endmodule

//--- dv/sgmii_rx_tb.sv
`timescale 1ns/100ps

module sgmii_rx_tb;

	localparam int clk_period = 200;
	localparam int timeout_cycles = 4000;
	localparam logic [31:0] seed = 32'hca178233;

	logic       clk_312p5mhz;
	logic       rst;
	logic [4:0] rx_bits;
	logic [2:0] rx_bit_count;
	logic       rx_dv;
	logic       rx_er;
	logic [7:0] rxd;
	logic       link_up;
	logic [1:0] link_speed;
	logic       synced;

	// Serial bit stream with the oldest bit first
	logic       bit_q[$];
	// Expected and received bytes with rx_er in bit 8
	logic [8:0] exp_byte_q[$];
	logic [8:0] got_q[$];
	// Expected link state with link_up in bit 2
	logic [2:0] exp_link_q[$];
	logic [31:0] rng;
	logic       drive_done;
	int         error_count;
	int         timeout_count;

	sgmii_rx_top dut_i (
		.clk_312p5mhz(clk_312p5mhz),
		.rst(rst),
		.rx_bits(rx_bits),
		.rx_bit_count(rx_bit_count),
		.rx_dv(rx_dv),
		.rx_er(rx_er),
		.rxd(rxd),
		.link_up(link_up),
		.link_speed(link_speed),
		.synced(synced)
	);

	initial begin
		clk_312p5mhz = 1'b0;
		forever #(clk_period / 2) clk_312p5mhz = ~clk_312p5mhz;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// MSB of the codeword is bit a and goes out first
	task automatic push_codeword(input logic [9:0] cw);
		for (int i = 9; i >= 0; i--)
			bit_q.push_back(cw[i]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus file

	task automatic load_stimulus();
		int fd;
		int r;
		int cnt;
		int n;
		int er;
		int up;
		int spd;
		string line;
		string tag;
		logic [9:0] cw[4];
		logic [7:0] b;
		fd = $fopen("dv/sgmii_rx_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file dv/sgmii_rx_stimulus.txt");
			error_count++;
			return;
		end
		// Junk prefix shifts the symbol boundary by three bits
		push_codeword(10'b0000000101);
		repeat (7)
			void'(bit_q.pop_front());
		while (!$feof(fd)) begin
			line = "";
			r = $fgets(line, fd);
			if (r > 0 && $sscanf(line, "%s", tag) == 1) begin
				case (tag)
					"C": begin
						r = $sscanf(line, "%s %d %d %h %h %h %h", tag, cnt, n,
							cw[0], cw[1], cw[2], cw[3]);
						repeat (cnt)
							for (int k = 0; k < n; k++)
								push_codeword(cw[k]);
					end
					"B": begin
						r = $sscanf(line, "%s %h %d", tag, b, er);
						exp_byte_q.push_back({er[0], b});
					end
					"L": begin
						r = $sscanf(line, "%s %d %d", tag, up, spd);
						exp_link_q.push_back({up[0], spd[1:0]});
					end
					// Comment lines
					default: begin
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// CDR model driving 3 to 5 bits per cycle on the falling edge

	initial begin
		int n;
		logic [4:0] val;
		rst = 1'b1;
		rx_bits = 5'd0;
		rx_bit_count = 3'd0;
		drive_done = 1'b0;
		error_count = 0;
		timeout_count = 0;
		rng = seed;
		load_stimulus();
		repeat (4) @(negedge clk_312p5mhz);
		rst = 1'b0;
		while (bit_q.size() >= 3) begin
			@(negedge clk_312p5mhz);
			rng = xorshift32(rng);
			n = 3 + int'(rng % 32'd3);
			if (n > bit_q.size())
				n = bit_q.size();
			val = 5'd0;
			// Oldest bit lands in the top position used
			for (int i = 0; i < n; i++)
				val = {val[3:0], bit_q.pop_front()};
			rx_bits = val;
			rx_bit_count = 3'(n);
		end
		@(negedge clk_312p5mhz);
		rx_bits = 5'd0;
		rx_bit_count = 3'd0;
		drive_done = 1'b1;
	end

	// Byte monitor sampling in the middle of the cycle
	always @(negedge clk_312p5mhz) begin
		if (!rst && rx_dv)
			got_q.push_back({rx_er, rxd});
	end

	////////////////////////////////////////////////////////////////////////////
	// Bounded waits

	task automatic wait_for_sync();
		int i;
		i = 0;
		while (!synced && i < timeout_cycles) begin
			@(negedge clk_312p5mhz);
			i++;
		end
		if (!synced) begin
			timeout_count++;
			$display("Timeout at %0t: synced never rose", $time);
		end
	endtask

	task automatic wait_for_link(input logic [2:0] prev);
		int i;
		i = 0;
		while ({link_up, link_speed} == prev && i < timeout_cycles) begin
			@(negedge clk_312p5mhz);
			i++;
		end
		if ({link_up, link_speed} == prev) begin
			timeout_count++;
			$display("Timeout at %0t: link state never changed", $time);
		end
	endtask

	task automatic wait_for_drive();
		int i;
		i = 0;
		while (!drive_done && i < timeout_cycles) begin
			@(negedge clk_312p5mhz);
			i++;
		end
		if (!drive_done) begin
			timeout_count++;
			$display("Timeout at %0t: the stimulus was not fully sent", $time);
		end
	endtask

	task automatic wait_for_bytes();
		int i;
		i = 0;
		while (got_q.size() < exp_byte_q.size() && i < timeout_cycles) begin
			@(negedge clk_312p5mhz);
			i++;
		end
		if (got_q.size() < exp_byte_q.size()) begin
			timeout_count++;
			$display("Timeout at %0t: too few received bytes", $time);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checker

	initial begin
		int nb;
		logic [2:0] link_prev;
		@(negedge clk_312p5mhz);
		wait_for_sync();
		// No frame yet, so no byte may have appeared
		assert (got_q.size() == 0) else begin
			error_count++;
			$display("[FAIL] %0t rx_dv count expected 0 got %0d", $time, got_q.size());
		end
		// Each listed link state follows one change of link_up or link_speed
		link_prev = {link_up, link_speed};
		foreach (exp_link_q[i]) begin
			wait_for_link(link_prev);
			assert (link_up == exp_link_q[i][2]) else begin
				error_count++;
				$display("[FAIL] %0t link_up expected %b got %b", $time,
					exp_link_q[i][2], link_up);
			end
			assert (link_speed == exp_link_q[i][1:0]) else begin
				error_count++;
				$display("[FAIL] %0t link_speed expected %0d got %0d", $time,
					exp_link_q[i][1:0], link_speed);
			end
			link_prev = {link_up, link_speed};
		end
		wait_for_drive();
		wait_for_bytes();
		assert (got_q.size() == exp_byte_q.size()) else begin
			error_count++;
			$display("[FAIL] %0t byte count expected %0d got %0d", $time,
				exp_byte_q.size(), got_q.size());
		end
		nb = (got_q.size() < exp_byte_q.size()) ? got_q.size() : exp_byte_q.size();
		for (int i = 0; i < nb; i++) begin
			assert (got_q[i][8] == exp_byte_q[i][8]) else begin
				error_count++;
				$display("[FAIL] %0t rx_er byte %0d expected %b got %b", $time, i,
					exp_byte_q[i][8], got_q[i][8]);
			end
			// Data under rx_er carries no meaning
			if (!exp_byte_q[i][8]) begin
				assert (got_q[i][7:0] == exp_byte_q[i][7:0]) else begin
					error_count++;
					$display("[FAIL] %0t rxd byte %0d expected %h got %h", $time, i,
						exp_byte_q[i][7:0], got_q[i][7:0]);
				end
			end
		end
		$display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- project.f
design/sgmii_rx_pkg.sv
design/sgmii_rx_gearbox.sv
design/sgmii_8b10b_decoder.sv
design/sgmii_rx_ctrl.sv
design/sgmii_gmii_rx.sv
design/sgmii_rx_top.sv
dv/sgmii_rx_tb.sv

//--- dv/sgmii_rx_stimulus.txt
# C count n cw0 cw1 cw2 cw3 : n 10-bit codewords (hex, first n used) sent count times
# B byte er : expected rx byte and rx_er flag, L up speed : expected link_up and link_speed
C 60 2 0fa 245 000 000
C 1 4 0fa 2aa 319 25a
C 1 4 305 2aa 319 25a
C 1 4 0fa 2aa 319 25a
C 1 2 305 296 000 000
L 1 2
C 4 2 0fa 245 000 000
C 1 4 368 319 2aa 155
C 1 2 0d6 2e8 000 000
B 55 0
B 23 0
B b5 0
B 4a 0
B cc 0
C 4 2 0fa 245 000 000
C 1 4 0fa 2aa 319 29a
C 1 4 305 2aa 319 29a
C 1 4 0fa 2aa 319 29a
C 1 2 305 296 000 000
L 1 1
C 4 2 0fa 245 000 000
C 1 4 368 319 1e8 32a
C 1 3 3c4 269 2e8 000
B 55 0
B 23 0
B fe 1
B b3 0
B 00 1
B 39 0
C 4 2 0fa 245 000 000
C 1 4 368 155 0d6 2e8
B 55 0
B 4a 0
B cc 0
C 4 2 0fa 245 000 000
C 1 4 0fa 2aa 319 255
C 1 2 305 296 000 000
L 0 1
C 12 2 0fa 245 000 000
